// ==== verilog/axi_lite_defines.svh ====
// AXI-lite subsystem widths and memory window parameters.
`ifndef AXI_LITE_DEFINES_SVH
`define AXI_LITE_DEFINES_SVH

// Byte address width on both buses.
`define AXI_ADDR_W 32

// Data path width.
`define AXI_DATA_W 64

// One strobe bit per data byte.
`define AXI_STRB_W 8

// Memory depth in data words.
`define RAM_WORDS 256

// First byte address of the memory window.
`define RAM_BASE 32'h0000_1000

`endif

// ==== verilog/axi_lite_pkg.sv ====
// AXI-lite channel payloads and response codes.
`include "axi_lite_defines.svh"

package axi_lite_pkg;

	// Response encoding; the high bit flags an error.
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		logic [2:0]             prot;
		logic                   valid;
	} axi_aw_t;

	typedef struct packed {
		logic [`AXI_DATA_W-1:0] data;
		logic [`AXI_STRB_W-1:0] strb;
		logic                   valid;
	} axi_w_t;

	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		logic [2:0]             prot;
		logic                   valid;
	} axi_ar_t;

	typedef struct packed {
		axi_resp_e resp;
		logic      valid;
	} axi_b_t;

	typedef struct packed {
		logic [`AXI_DATA_W-1:0] data;
		axi_resp_e              resp;
		logic                   valid;
	} axi_r_t;

	// Ready bits driven by the master.
	typedef struct packed {
		logic bready;
		logic rready;
	} axi_mst_rdy_t;

	// Ready bits driven by the slave.
	typedef struct packed {
		logic awready;
		logic wready;
		logic arready;
	} axi_slv_rdy_t;

endpackage

// ==== verilog/bus_cmd_pkg.sv ====
// Host bus requests, master commands and controller state encodings.
`include "axi_lite_defines.svh"

package bus_cmd_pkg;

	// Wishbone classic request from the host.
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`AXI_ADDR_W-1:0] adr;
		logic [`AXI_DATA_W-1:0] dat;
		logic [`AXI_STRB_W-1:0] sel;
	} wb_req_t;

	typedef struct packed {
		logic                   ack;
		logic                   err;
		logic [`AXI_DATA_W-1:0] dat;
	} wb_rsp_t;

	// One single-beat command; start is a pulse.
	typedef struct packed {
		logic                   start;
		logic                   we;
		logic [`AXI_ADDR_W-1:0] addr;
		logic [`AXI_DATA_W-1:0] wdata;
		logic [`AXI_STRB_W-1:0] strb;
	} mst_cmd_t;

	typedef struct packed {
		logic                   done;
		logic                   err;
		logic [`AXI_DATA_W-1:0] rdata;
	} mst_res_t;

	typedef enum logic [1:0] {br_idle, br_busy, br_term} bridge_state_e;

	typedef enum logic [1:0] {ram_idle, ram_wresp, ram_rresp} ram_state_e;

endpackage

// ==== verilog/wb_cmd_bridge.sv ====
// Wishbone classic slave that turns each bus cycle into one master command.
`timescale 1ns/100ps
`include "axi_lite_defines.svh"

module wb_cmd_bridge (
	input  logic                  clk,
	input  logic                  arst_n,
	input  bus_cmd_pkg::wb_req_t  wb_req,
	output bus_cmd_pkg::wb_rsp_t  wb_rsp,
	output bus_cmd_pkg::mst_cmd_t cmd,
	input  bus_cmd_pkg::mst_res_t res
);
	import bus_cmd_pkg::*;

	bridge_state_e          state_q;
	logic                   start_q;
	logic                   ack_q;
	logic                   err_q;
	logic                   we_q;
	logic [`AXI_ADDR_W-1:0] addr_q;
	logic [`AXI_DATA_W-1:0] wdata_q;
	logic [`AXI_STRB_W-1:0] strb_q;
	logic [`AXI_DATA_W-1:0] rdata_q;
	logic                   req_new;

	// A new cycle is only taken from idle.
	assign req_new = (state_q == br_idle) && wb_req.cyc && wb_req.stb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= br_idle;
			start_q <= 1'b0;
			ack_q   <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			// Start and the terminations are single-cycle pulses.
			start_q <= 1'b0;
			ack_q   <= 1'b0;
			err_q   <= 1'b0;
			case (state_q)
				br_idle: begin
					if (req_new) begin
						start_q <= 1'b1;
						state_q <= br_busy;
					end
				end
				br_busy: begin
					if (res.done) begin
						ack_q   <= ~res.err;
						err_q   <= res.err;
						state_q <= br_term;
					end
				end
				br_term: begin
					// Hold here until the host releases stb.
					if (!wb_req.stb)
						state_q <= br_idle;
				end
				default: state_q <= br_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_new) begin
			we_q    <= wb_req.we;
			addr_q  <= wb_req.adr;
			wdata_q <= wb_req.dat;
			strb_q  <= wb_req.sel;
		end
		if ((state_q == br_busy) && res.done)
			rdata_q <= res.rdata;
	end

	assign cmd.start = start_q;
	assign cmd.we    = we_q;
	assign cmd.addr  = addr_q;
	assign cmd.wdata = wdata_q;
	assign cmd.strb  = strb_q;

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.err = err_q;
	assign wb_rsp.dat = rdata_q;

endmodule

// ==== verilog/axi_lite_mst.sv ====
// Single-transaction AXI-lite master built from set/reset handshake flags.
`timescale 1ns/100ps
`include "axi_lite_defines.svh"

module axi_lite_mst (
	input  logic                       clk,
	input  logic                       arst_n,
	input  bus_cmd_pkg::mst_cmd_t      cmd,
	output bus_cmd_pkg::mst_res_t      res,
	output axi_lite_pkg::axi_aw_t      aw,
	output axi_lite_pkg::axi_w_t       w,
	output axi_lite_pkg::axi_ar_t      ar,
	output axi_lite_pkg::axi_mst_rdy_t mrdy,
	input  axi_lite_pkg::axi_b_t       b,
	input  axi_lite_pkg::axi_r_t       r,
	input  axi_lite_pkg::axi_slv_rdy_t srdy
);

	logic                   busy_q;
	logic                   accept;
	logic                   start_single_write;
	logic                   start_single_read;

	logic                   awvalid_set;
	logic                   awvalid_rst;
	logic                   awvalid_q;
	logic                   wvalid_set;
	logic                   wvalid_rst;
	logic                   wvalid_q;
	logic                   bready_set;
	logic                   bready_rst;
	logic                   bready_q;
	logic                   arvalid_set;
	logic                   arvalid_rst;
	logic                   arvalid_q;
	logic                   rready_set;
	logic                   rready_rst;
	logic                   rready_q;

	logic                   write_done;
	logic                   read_done;
	logic                   write_resp_error;
	logic                   read_resp_error;

	logic [`AXI_ADDR_W-1:0] addr_q;
	logic [`AXI_DATA_W-1:0] wdata_q;
	logic [`AXI_STRB_W-1:0] strb_q;

	// A command is taken only when nothing is open.
	assign accept             = cmd.start & ~busy_q;
	assign start_single_write = accept & cmd.we;
	assign start_single_read  = accept & ~cmd.we;

	assign awvalid_set = start_single_write;
	assign awvalid_rst = ~awvalid_set & (srdy.awready & awvalid_q);
	assign wvalid_set  = start_single_write;
	assign wvalid_rst  = ~wvalid_set & (srdy.wready & wvalid_q);
	assign bready_set  = b.valid & ~bready_q;
	assign bready_rst  = bready_q;

	assign arvalid_set = start_single_read;
	assign arvalid_rst = ~arvalid_set & (srdy.arready & arvalid_q);
	assign rready_set  = r.valid & ~rready_q;
	assign rready_rst  = rready_q;

	// Set wins over reset on every flag.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			bready_q  <= 1'b0;
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
		end else begin
			if (awvalid_set)
				awvalid_q <= 1'b1;
			else if (awvalid_rst)
				awvalid_q <= 1'b0;
			if (wvalid_set)
				wvalid_q <= 1'b1;
			else if (wvalid_rst)
				wvalid_q <= 1'b0;
			if (bready_set)
				bready_q <= 1'b1;
			else if (bready_rst)
				bready_q <= 1'b0;
			if (arvalid_set)
				arvalid_q <= 1'b1;
			else if (arvalid_rst)
				arvalid_q <= 1'b0;
			if (rready_set)
				rready_q <= 1'b1;
			else if (rready_rst)
				rready_q <= 1'b0;
		end
	end

	// Open from accept until the response handshake.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			busy_q <= 1'b0;
		else if (accept)
			busy_q <= 1'b1;
		else if (res.done)
			busy_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= cmd.addr;
			wdata_q <= cmd.wdata;
			strb_q  <= cmd.strb;
		end
	end

	assign write_done       = bready_q & b.valid;
	assign read_done        = rready_q & r.valid;
	assign write_resp_error = write_done & b.resp[1];
	assign read_resp_error  = read_done & r.resp[1];

	assign res.done  = write_done | read_done;
	assign res.err   = write_resp_error | read_resp_error;
	assign res.rdata = r.data;

	// Writes are data/unprivileged, reads privileged.
	assign aw.addr  = addr_q;
	assign aw.prot  = 3'b000;
	assign aw.valid = awvalid_q;
	assign w.data   = wdata_q;
	assign w.strb   = strb_q;
	assign w.valid  = wvalid_q;
	assign ar.addr  = addr_q;
	assign ar.prot  = 3'b001;
	assign ar.valid = arvalid_q;

	assign mrdy.bready = bready_q;
	assign mrdy.rready = rready_q;

endmodule

// ==== verilog/axi_lite_ram.sv ====
// AXI-lite memory slave with byte strobes and a single address window.
`timescale 1ns/100ps
`include "axi_lite_defines.svh"

module axi_lite_ram (
	input  logic                       clk,
	input  logic                       arst_n,
	input  axi_lite_pkg::axi_aw_t      aw,
	input  axi_lite_pkg::axi_w_t       w,
	input  axi_lite_pkg::axi_ar_t      ar,
	input  axi_lite_pkg::axi_mst_rdy_t mrdy,
	output axi_lite_pkg::axi_b_t       b,
	output axi_lite_pkg::axi_r_t       r,
	output axi_lite_pkg::axi_slv_rdy_t srdy
);
	import axi_lite_pkg::*;
	import bus_cmd_pkg::*;

	localparam int lane_w = $clog2(`AXI_STRB_W);
	localparam int idx_w  = $clog2(`RAM_WORDS);
	localparam logic [`AXI_ADDR_W-1:0] win_size = `RAM_WORDS * `AXI_STRB_W;

	ram_state_e             state_q;
	logic                   wr_rdy_q;
	logic                   rd_rdy_q;
	logic                   wr_fire;
	logic                   rd_fire;

	logic [`AXI_ADDR_W-1:0] aw_off;
	logic [`AXI_ADDR_W-1:0] ar_off;
	logic                   aw_hit;
	logic                   ar_hit;
	logic [idx_w-1:0]       aw_idx;
	logic [idx_w-1:0]       ar_idx;

	logic [`AXI_DATA_W-1:0] mem [`RAM_WORDS];
	axi_resp_e              bresp_q;
	axi_resp_e              rresp_q;
	logic [`AXI_DATA_W-1:0] rdata_q;

	// Offsets below the base wrap around and fall outside the window.
	assign aw_off = aw.addr - `RAM_BASE;
	assign ar_off = ar.addr - `RAM_BASE;
	assign aw_hit = aw_off < win_size;
	assign ar_hit = ar_off < win_size;
	assign aw_idx = aw_off[lane_w +: idx_w];
	assign ar_idx = ar_off[lane_w +: idx_w];

	assign wr_fire = (state_q == ram_idle) & wr_rdy_q & aw.valid & w.valid;
	assign rd_fire = (state_q == ram_idle) & rd_rdy_q & ar.valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q  <= ram_idle;
			wr_rdy_q <= 1'b0;
			rd_rdy_q <= 1'b0;
		end else begin
			// Ready bits last one cycle.
			wr_rdy_q <= 1'b0;
			rd_rdy_q <= 1'b0;
			case (state_q)
				ram_idle: begin
					if (wr_fire)
						state_q <= ram_wresp;
					else if (rd_fire)
						state_q <= ram_rresp;
					else if (aw.valid && w.valid)
						wr_rdy_q <= 1'b1;
					else if (ar.valid)
						rd_rdy_q <= 1'b1;
				end
				ram_wresp: begin
					if (mrdy.bready)
						state_q <= ram_idle;
				end
				ram_rresp: begin
					if (mrdy.rready)
						state_q <= ram_idle;
				end
				default: state_q <= ram_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp_q <= aw_hit ? resp_okay : resp_slverr;
			if (aw_hit) begin
				for (int i = 0; i < `AXI_STRB_W; i++) begin
					if (w.strb[i])
						mem[aw_idx][i*8 +: 8] <= w.data[i*8 +: 8];
				end
			end
		end
		if (rd_fire) begin
			rresp_q <= ar_hit ? resp_okay : resp_slverr;
			rdata_q <= ar_hit ? mem[ar_idx] : '0;
		end
	end

	assign srdy.awready = wr_rdy_q;
	assign srdy.wready  = wr_rdy_q;
	assign srdy.arready = rd_rdy_q;

	// Response valids follow the state and hold until taken.
	assign b.valid = (state_q == ram_wresp);
	assign b.resp  = bresp_q;
	assign r.valid = (state_q == ram_rresp);
	assign r.resp  = rresp_q;
	assign r.data  = rdata_q;

endmodule

// ==== verilog/axi_lite_sys.sv ====
// Host bus master subsystem joining the Wishbone bridge, AXI-lite master and memory.
`timescale 1ns/100ps

module axi_lite_sys (
	input  logic                 clk,
	input  logic                 arst_n,
	input  bus_cmd_pkg::wb_req_t wb_req,
	output bus_cmd_pkg::wb_rsp_t wb_rsp
);
	import axi_lite_pkg::*;
	import bus_cmd_pkg::*;

	mst_cmd_t     cmd;
	mst_res_t     res;
	axi_aw_t      aw;
	axi_w_t       w;
	axi_ar_t      ar;
	axi_mst_rdy_t mrdy;
	axi_b_t       b;
	axi_r_t       r;
	axi_slv_rdy_t srdy;

	wb_cmd_bridge u_bridge (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.cmd    (cmd),
		.res    (res)
	);

	axi_lite_mst u_mst (
		.clk    (clk),
		.arst_n (arst_n),
		.cmd    (cmd),
		.res    (res),
		.aw     (aw),
		.w      (w),
		.ar     (ar),
		.mrdy   (mrdy),
		.b      (b),
		.r      (r),
		.srdy   (srdy)
	);

	axi_lite_ram u_ram (
		.clk    (clk),
		.arst_n (arst_n),
		.aw     (aw),
		.w      (w),
		.ar     (ar),
		.mrdy   (mrdy),
		.b      (b),
		.r      (r),
		.srdy   (srdy)
	);

endmodule

// ==== verif/tb_axi_lite_sys.sv ====
// Testbench for the Wishbone to AXI-lite subsystem, checked against a word memory model.
`timescale 1ns/100ps
`include "axi_lite_defines.svh"

module tb_axi_lite_sys;
	import bus_cmd_pkg::*;

	localparam int idx_w        = $clog2(`RAM_WORDS);
	localparam int term_timeout = 64;

	logic                   clk;
	logic                   arst_n;
	wb_req_t                wb_req;
	wb_rsp_t                wb_rsp;
	logic [31:0]            lfsr_q;
	logic [`AXI_DATA_W-1:0] model_mem [`RAM_WORDS];
	int                     err_count;
	int                     check_count;
	int                     timeouts;

	axi_lite_sys u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [63:0] rand_data();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = take_bits(32);
		lo = take_bits(32);
		return {hi, lo};
	endfunction

	function automatic logic [31:0] addr_of(input int idx);
		return `RAM_BASE + 32'(idx * 8);
	endfunction

	function automatic logic in_window(input logic [31:0] addr);
		return addr >= `RAM_BASE && addr < `RAM_BASE + 32'(`RAM_WORDS * 8);
	endfunction

	function automatic int word_of(input logic [31:0] addr);
		logic [31:0] off;
		off = addr - `RAM_BASE;
		return int'(off[3 +: idx_w]);
	endfunction

	// Below the base, past the end, far above, or near zero.
	function automatic logic [31:0] outside_addr();
		logic [1:0]  kind;
		logic [31:0] addr;
		kind = 2'(take_bits(2));
		case (kind)
			2'd0:    addr = `RAM_BASE - 32'(8 * (1 + take_bits(4)));
			2'd1:    addr = `RAM_BASE + 32'(`RAM_WORDS * 8) + 32'(8 * take_bits(8));
			2'd2:    addr = {4'h8, 25'(take_bits(25)), 3'b000};
			default: addr = 32'(8 * take_bits(8));
		endcase
		return addr;
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		err_count++;
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (err_count == errs_before)
			$display("[test %0d] %s: pass", num, name);
		else
			$display("[test %0d] %s: FAIL with %0d errors", num, name, err_count - errs_before);
	endtask

	// One Wishbone classic cycle; stb drops in the cycle after the termination.
	task automatic bus_cycle(input logic we, input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] sel, output logic [63:0] rdata, output logic got_err);
		int   waited;
		logic seen;
		rdata   = '0;
		got_err = 1'b0;
		if (timeouts != 0)
			return;
		@(negedge clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = addr;
		wb_req.dat = data;
		wb_req.sel = sel;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < term_timeout) begin
			@(negedge clk);
			waited++;
			seen = wb_rsp.ack | wb_rsp.err;
		end
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		if (!seen) begin
			$display("Timeout: %s at address %h got neither ack nor err within %0d cycles (%0t)",
				we ? "write" : "read", addr, term_timeout, $time);
			timeouts++;
			err_count++;
		end else begin
			rdata   = wb_rsp.dat;
			got_err = wb_rsp.err;
			check_count++;
			if (wb_rsp.ack && wb_rsp.err)
				report_error($sformatf("ack and err both high at address %h", addr));
			@(negedge clk);
			check_count++;
			if (wb_rsp.ack || wb_rsp.err)
				report_error($sformatf("second termination after access to %h", addr));
		end
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] sel);
		logic [63:0] rdata;
		logic        got_err;
		logic        hit;
		int          idx;
		hit = in_window(addr);
		bus_cycle(1'b1, addr, data, sel, rdata, got_err);
		if (timeouts != 0)
			return;
		check_count++;
		if (got_err !== !hit)
			report_error($sformatf("write to %h gave err=%b, expected %b", addr, got_err, !hit));
		if (hit) begin
			idx = word_of(addr);
			for (int i = 0; i < 8; i++) begin
				if (sel[i])
					model_mem[idx][i*8 +: 8] = data[i*8 +: 8];
			end
		end
	endtask

	task automatic read_word(input logic [31:0] addr);
		logic [63:0] rdata;
		logic [63:0] exp;
		logic        got_err;
		logic        hit;
		hit = in_window(addr);
		exp = hit ? model_mem[word_of(addr)] : 64'h0;
		bus_cycle(1'b0, addr, 64'h0, 8'h00, rdata, got_err);
		if (timeouts != 0)
			return;
		check_count++;
		if (got_err !== !hit)
			report_error($sformatf("read of %h gave err=%b, expected %b", addr, got_err, !hit));
		check_count++;
		if (rdata !== exp)
			report_error($sformatf("read of %h got %h expected %h", addr, rdata, exp));
	endtask

	initial begin
		int          base;
		int          gap;
		logic [31:0] addr;
		logic [7:0]  sel;
		wb_req      = '0;
		arst_n      = 1'b0;
		lfsr_q      = 32'h0bd3_d7d8;
		err_count   = 0;
		check_count = 0;
		timeouts    = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		base = err_count;
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			check_count++;
			if (wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0)
				report_error("termination seen with no request");
		end
		report_test(1, "quiet after reset", base);

		// Fill every word with a pattern built from its address, then read it all back.
		base = err_count;
		for (int i = 0; i < `RAM_WORDS; i++)
			write_word(addr_of(i), {addr_of(i), ~addr_of(i)}, 8'hff);
		for (int i = 0; i < `RAM_WORDS; i++)
			read_word(addr_of(i));
		for (int i = 0; i < 32; i++) begin
			addr = addr_of(int'(take_bits(idx_w)));
			write_word(addr, rand_data(), 8'hff);
			read_word(addr);
		end
		report_test(2, "full-strobe write and read", base);

		base = err_count;
		for (int i = 0; i < 48; i++) begin
			addr = addr_of(int'(take_bits(idx_w)));
			write_word(addr, rand_data(), 8'(take_bits(8)));
			read_word(addr);
			if (i % 4 == 3)
				read_word(addr_of(int'(take_bits(idx_w))));
		end
		report_test(3, "byte-strobe writes", base);

		// The word that a broken window check would alias to must stay unchanged.
		base = err_count;
		for (int i = 0; i < 24; i++) begin
			addr = outside_addr();
			write_word(addr, rand_data(), 8'hff);
			read_word(addr);
			read_word(addr_of(int'(addr[3 +: idx_w])));
		end
		report_test(4, "accesses outside the window", base);

		base = err_count;
		for (int i = 0; i < 200; i++) begin
			if (take_bits(4) == 32'd0)
				addr = outside_addr();
			else
				addr = addr_of(int'(take_bits(idx_w)));
			if (take_bits(1) != 32'd0) begin
				sel = (take_bits(1) != 32'd0) ? 8'hff : 8'(take_bits(8));
				write_word(addr, rand_data(), sel);
			end else begin
				read_word(addr);
			end
			gap = int'(take_bits(3));
			for (int g = 0; g < gap; g++) begin
				@(negedge clk);
				check_count++;
				if (wb_rsp.ack || wb_rsp.err)
					report_error("termination during an idle gap");
			end
		end
		report_test(5, "random mixed sequence", base);

		$display("Summary: %0d checks, %0d errors, %0d timeouts", check_count, err_count, timeouts);
		if (err_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/axi_lite_pkg.sv
verilog/bus_cmd_pkg.sv
verilog/wb_cmd_bridge.sv
verilog/axi_lite_mst.sv
verilog/axi_lite_ram.sv
verilog/axi_lite_sys.sv
verif/tb_axi_lite_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module tb_axi_lite_sys -f all.f -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log; echo "Simulation build or run failed"; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
